// ==== bench/sm83_testdata.hex ====
// per test, first line: program byte count, then the program bytes from address 0
// second line: write count, writes as adr hi adr lo data, then pc hi pc lo a f b c d e h l
16 3e 12 06 34 0e 56 16 78 1e 9a 26 bc 2e de 78 41 4a 53 5c 65 6f 76  // loads
00 00 16 34 00 56 78 9a bc de 34
08 3e 39 06 01 80 c6 c6 76  // add
00 00 08 00 b0 01 00 00 00 00 00
0b 3e f0 06 20 80 ce ef 0e 7f 89 76  // adc
00 00 0b 80 20 20 7f 00 00 00 00
08 3e 10 06 01 90 d6 0f 76  // sub
00 00 08 00 c0 01 00 00 00 00 00
0b 3e 10 06 20 90 0e f0 99 de fe 76  // sbc
00 00 0b 00 c0 20 f0 00 00 00 00
0a 3e ff c6 f4 16 3c a2 e6 0c 76  // and
00 00 0a 00 a0 00 00 3c 00 00 00
0f 3e ff c6 5b ee 0f 1e 55 ab 26 30 b4 f6 c0 76  // xor and or
00 00 0f f0 00 00 00 00 55 30 00
08 3e 42 0e 42 b9 fe 50 76  // cp
00 00 08 42 50 00 42 00 00 00 00
0f 3e ff c6 01 06 ff 04 0d 3c 15 1c 2d 24 25 76  // inc and dec
00 00 0f 01 d0 00 ff ff 01 00 ff
11 26 c0 2e 10 3e a5 77 2c 06 3c 70 2d 4e 2c 56 86 76  // (hl) stores and loads
02 c0 10 a5 c0 11 3c 00 11 e1 20 3c a5 3c 00 c0 11
16 00 3e 11 c3 0a 00 3e 99 06 77 06 22 c3 14 00 76 76 3c 3c 3c 80 76  // jumps
00 00 16 33 00 22 00 00 00 00 00

// ==== sim.f ====
hw/sm83_pkg.sv
hw/sm83_bus.sv
hw/sm83_control.sv
hw/sm83_alu.sv
hw/sm83_regs.sv
hw/sm83.sv
bench/sm83_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module sm83_tb -o sm83_sim &&
./obj_dir/sm83_sim || exit 1

// ==== bench/sm83_tb.sv ====
`timescale 1ns/1ps

module sm83_tb;
	import sm83_pkg::*;

	localparam int NUM_TESTS  = 11;
	localparam int DATA_DEPTH = 512;
	localparam int MAX_DELAY  = 3;
	localparam int BUS_CYCLE  = MAX_DELAY + 5;  // clocks per handshake at the worst delay

	logic       clk   = 1'b0;
	logic       reset = 1'b1;
	logic       ack   = 1'b0;
	word_t      din   = '0;
	logic       req, halted;
	bus_req_t   bus;
	cpu_state_t state;

	word_t       testdata [DATA_DEPTH];
	word_t       mem [65536];
	bus_req_t    exp_writes [$];
	logic [31:0] seed = 32'h7d44_28e1;
	string       test_name = "";
	int          limit_cycles = 0;
	string       names [NUM_TESTS] = '{"loads", "add", "adc", "sub", "sbc", "and",
		"xor_or", "cp", "inc_dec", "mem", "jump_halt"};

	sm83 dut (.clk, .reset, .ack, .din, .req, .bus, .halted, .state);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_write(input bus_req_t expected, input bus_req_t actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch in %s: write expected %h=%h, actual %h=%h",
				test_name, expected.adr, expected.dout, actual.adr, actual.dout));
	endtask

	task automatic check_state(input cpu_state_t expected, input cpu_state_t actual);
		if (actual !== expected)
			fail_run($sformatf("mismatch in %s: state expected %h, actual %h",
				test_name, expected, actual));
	endtask

	task automatic check_stable(input bus_req_t held);
		if (bus !== held)
			fail_run($sformatf("bus changed while req was high in test %s", test_name));
	endtask

	function automatic int program_bytes();
		int p;
		int total;
		int nw;
		p = 0;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += int'(testdata[p]);
			p += int'(testdata[p]) + 1;
			nw = int'(testdata[p]);
			p += 3 * nw + 11;  // write count, writes, final state
		end
		return total;
	endfunction

	task automatic load_test(inout int p, output cpu_state_t expected);
		int          n;
		bus_req_t    w;
		logic [79:0] raw;
		for (int a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0];
		n = int'(testdata[p]);
		for (int i = 0; i < n; i++)
			mem[i] = testdata[p + 1 + i];
		p += n + 1;
		n = int'(testdata[p]);
		p++;
		exp_writes.delete();
		for (int i = 0; i < n; i++) begin
			w = {testdata[p], testdata[p + 1], testdata[p + 2], 1'b1};
			exp_writes.push_back(w);
			p += 3;
		end
		raw = '0;
		for (int i = 0; i < 10; i++)
			raw = {raw[71:0], testdata[p + i]};  // pc, af, bc, de, hl
		expected = raw;
		p += 10;
	endtask

	// four-phase slave with random ack latency
	always begin : memory_model
		bus_req_t held;
		int       delay;
		@(negedge clk);
		if (req) begin
			held  = bus;
			delay = int'(next_random() >> 30);
			repeat (delay) begin
				@(negedge clk);
				check_stable(held);
			end
			if (held.wr) begin
				if (exp_writes.size() == 0) begin
					fail_run($sformatf("extra write to %h in test %s", held.adr, test_name));
				end else begin
					check_write(exp_writes.pop_front(), held);
					mem[held.adr] = held.dout;
				end
			end else begin
				din = mem[held.adr];
			end
			ack = 1'b1;
			@(negedge clk);
			while (req) begin
				check_stable(held);
				@(negedge clk);
			end
			ack = 1'b0;
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		fail_run($sformatf("timeout, no halt seen in test %s", test_name));
	end

	initial begin : run_tests
		int         p;
		cpu_state_t expected;
		$readmemh("bench/sm83_testdata.hex", testdata);
		limit_cycles = program_bytes() * 4 * BUS_CYCLE + NUM_TESTS * 20 + 200;
		p = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(negedge clk);
			test_name = names[t];
			reset = 1'b1;
			load_test(p, expected);
			repeat (8) @(negedge clk);
			reset = 1'b0;
			while (!halted)
				@(negedge clk);
			check_state(expected, state);
			if (exp_writes.size() != 0)
				fail_run($sformatf("%0d writes missing in test %s", exp_writes.size(), test_name));
			repeat (8) begin  // core must stay quiet
				@(negedge clk);
				if (req)
					fail_run($sformatf("request after halt in test %s", test_name));
			end
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== hw/sm83.sv ====
`timescale 1ns/1ps

module sm83 (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ack,
	input  sm83_pkg::word_t      din,
	output logic                 req,
	output sm83_pkg::bus_req_t   bus,
	output logic                 halted,
	output sm83_pkg::cpu_state_t state
);
	import sm83_pkg::*;

	logic     start, wr, adr_sel, ir_we, done, src_sel;
	logic     reg_we, alu_we, flags_we, pc_inc, pc_load_lo, pc_load_hi;
	reg_sel_t reg_dst, reg_src;
	alu_op_t  alu_op;
	word_t    opcode, dl, src_out, acc, operand, alu_result, reg_din;
	adr_t     hl, pc, adr;
	flags_t   flags;

	// internal byte bus
	assign operand = src_sel ? dl : src_out;
	assign reg_din = alu_we ? alu_result : operand;
	assign adr     = adr_sel ? hl : pc;

	sm83_bus bus_unit (
		.clk, .reset, .start, .wr, .adr, .wdata(src_out), .ir_we,
		.ack, .din, .req, .bus, .done, .opcode, .dl
	);

	sm83_control ctl (
		.clk, .reset, .opcode, .done,
		.start, .wr, .adr_sel, .ir_we, .reg_we, .reg_dst, .reg_src, .src_sel,
		.alu_op, .alu_we, .flags_we, .pc_inc, .pc_load_lo, .pc_load_hi, .halted
	);

	sm83_alu alu (
		.clk, .reset, .op(alu_op), .a(acc), .b(operand), .we_flags(flags_we),
		.result(alu_result), .flags
	);

	sm83_regs regs (
		.clk, .reset, .dst(reg_dst), .src(reg_src), .we(reg_we), .din(reg_din),
		.pc_inc, .pc_load_lo, .pc_load_hi, .flags,
		.src_out, .acc, .hl, .pc, .state
	);

endmodule

// ==== hw/sm83_regs.sv ====
`timescale 1ns/1ps

module sm83_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  sm83_pkg::reg_sel_t   dst,
	input  sm83_pkg::reg_sel_t   src,
	input  logic                 we,
	input  sm83_pkg::word_t      din,
	input  logic                 pc_inc,
	input  logic                 pc_load_lo,
	input  logic                 pc_load_hi,
	input  sm83_pkg::flags_t     flags,
	output sm83_pkg::word_t      src_out,
	output sm83_pkg::word_t      acc,
	output sm83_pkg::adr_t       hl,
	output sm83_pkg::adr_t       pc,
	output sm83_pkg::cpu_state_t state
);
	import sm83_pkg::*;

	word_t rf [8];  // slot 6 is (HL) and stays empty
	word_t jp_lo;
	adr_t  pc_q;

	// jump target goes straight out so the next fetch uses it
	assign pc = pc_load_hi ? adr_t'({din, jp_lo}) : pc_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				rf[i] <= '0;
			pc_q <= '0;
		end else begin
			if (we && dst != REG_MEM)
				rf[dst] <= din;
			if (pc_inc)
				pc_q <= adr_t'(pc + ADR_WIDTH'(1));
		end
	end

	always_ff @(posedge clk)
		if (pc_load_lo)
			jp_lo <= din;  // low target byte

	assign src_out = rf[src];
	assign acc     = rf[REG_A];
	assign hl      = '{hi: rf[REG_H], lo: rf[REG_L]};

	assign state = '{
		pc: pc_q,
		af: {rf[REG_A], flags, 4'b0000},
		bc: {rf[REG_B], rf[REG_C]},
		de: {rf[REG_D], rf[REG_E]},
		hl: {rf[REG_H], rf[REG_L]}
	};

endmodule

// ==== hw/sm83_alu.sv ====
`timescale 1ns/1ps

module sm83_alu (
	input  logic              clk,
	input  logic              reset,
	input  sm83_pkg::alu_op_t op,
	input  sm83_pkg::word_t   a,
	input  sm83_pkg::word_t   b,
	input  logic              we_flags,
	output sm83_pkg::word_t   result,
	output sm83_pkg::flags_t  flags
);
	import sm83_pkg::*;

	logic   carry_in;
	logic   [8:0] add_full, sub_full;
	logic   [4:0] add_half, sub_half;  // bit 4 is the half carry or borrow
	word_t  res;
	flags_t flags_nx;

	always_comb begin
		carry_in = (op == ALU_ADC || op == ALU_SBC) ? flags.c : 1'b0;
		add_full = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};
		add_half = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, carry_in};
		sub_full = {1'b0, a} - {1'b0, b} - {8'd0, carry_in};
		sub_half = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, carry_in};
		res      = b;
		flags_nx = flags;
		case (op)
			ALU_ADD, ALU_ADC: begin
				res      = add_full[7:0];
				flags_nx = '{z: 1'b0, n: 1'b0, h: add_half[4], c: add_full[8]};
			end
			ALU_SUB, ALU_SBC, ALU_CP: begin
				res      = sub_full[7:0];
				flags_nx = '{z: 1'b0, n: 1'b1, h: sub_half[4], c: sub_full[8]};
			end
			ALU_AND: begin
				res      = a & b;
				flags_nx = '{z: 1'b0, n: 1'b0, h: 1'b1, c: 1'b0};
			end
			ALU_XOR, ALU_OR: begin
				res      = (op == ALU_XOR) ? a ^ b : a | b;
				flags_nx = '{z: 1'b0, n: 1'b0, h: 1'b0, c: 1'b0};
			end
			ALU_INC: begin
				res        = b + 8'd1;
				flags_nx.n = 1'b0;
				flags_nx.h = &b[3:0];
			end
			ALU_DEC: begin
				res        = b - 8'd1;
				flags_nx.n = 1'b1;
				flags_nx.h = ~|b[3:0];
			end
			default: ;  // pass b through
		endcase
		if (op != ALU_PASS)
			flags_nx.z = res == '0;
	end

	assign result = res;

	always_ff @(posedge clk) begin
		if (reset)
			flags <= '0;
		else if (we_flags)
			flags <= flags_nx;
	end

endmodule

// ==== hw/sm83_control.sv ====
`timescale 1ns/1ps

module sm83_control (
	input  logic               clk,
	input  logic               reset,
	input  sm83_pkg::word_t    opcode,
	input  logic               done,
	output logic               start,
	output logic               wr,
	output logic               adr_sel,  // 0 pc, 1 hl
	output logic               ir_we,
	output logic               reg_we,
	output sm83_pkg::reg_sel_t reg_dst,
	output sm83_pkg::reg_sel_t reg_src,
	output logic               src_sel,  // 0 register, 1 data latch
	output sm83_pkg::alu_op_t  alu_op,
	output logic               alu_we,
	output logic               flags_we,
	output logic               pc_inc,
	output logic               pc_load_lo,
	output logic               pc_load_hi,
	output logic               halted
);
	import sm83_pkg::*;

	logic [1:0] x;
	logic [2:0] y, z;
	logic       is_halt, is_jp, is_ld_imm, is_inc, is_dec;
	logic       is_ld, is_ld_load, is_ld_store, is_alu, is_alu_mem, is_alu_imm;
	logic [1:0] n_cyc, m;
	logic       busy, issue, last, halt_now;

	assign x = opcode[OP_X_LSB +: 2];
	assign y = opcode[OP_Y_LSB +: 3];
	assign z = opcode[OP_Z_LSB +: 3];

	assign is_halt     = opcode == OP_HALT;
	assign is_jp       = opcode == OP_JP;
	assign is_ld_imm   = x == 2'd0 && z == 3'd6 && y != REG_MEM;
	assign is_inc      = x == 2'd0 && z == 3'd4 && y != REG_MEM;
	assign is_dec      = x == 2'd0 && z == 3'd5 && y != REG_MEM;
	assign is_ld       = x == 2'd1 && !is_halt;
	assign is_ld_load  = is_ld && z == REG_MEM;
	assign is_ld_store = is_ld && y == REG_MEM;
	assign is_alu      = x == 2'd2;
	assign is_alu_mem  = is_alu && z == REG_MEM;
	assign is_alu_imm  = x == 2'd3 && z == 3'd6;

	always_comb begin
		if (is_jp)
			n_cyc = 2'd3;
		else if (is_ld_imm || is_ld_load || is_ld_store || is_alu_mem || is_alu_imm)
			n_cyc = 2'd2;
		else
			n_cyc = 2'd1;
	end

	assign issue = !busy && !halted;
	assign last  = m == n_cyc - 2'd1;  // last cycle is the next fetch

	always_comb begin
		start      = 1'b0;
		wr         = 1'b0;
		adr_sel    = 1'b0;
		ir_we      = 1'b0;
		reg_we     = 1'b0;
		reg_dst    = reg_sel_t'(y);
		reg_src    = reg_sel_t'(z);
		src_sel    = 1'b0;
		alu_op     = ALU_PASS;
		alu_we     = 1'b0;
		flags_we   = 1'b0;
		pc_inc     = 1'b0;
		pc_load_lo = 1'b0;
		pc_load_hi = 1'b0;
		halt_now   = 1'b0;
		if (issue && is_halt) begin
			halt_now = 1'b1;
		end else if (issue && last) begin
			start  = 1'b1;
			ir_we  = 1'b1;
			pc_inc = 1'b1;
			// writes of the finishing instruction ride on the fetch
			if (is_ld && !is_ld_store) begin
				reg_we  = 1'b1;
				src_sel = is_ld_load;
			end
			if (is_ld_imm) begin
				reg_we  = 1'b1;
				src_sel = 1'b1;
			end
			if (is_alu || is_alu_imm) begin
				alu_op   = alu_op_t'({1'b0, y});
				alu_we   = 1'b1;
				flags_we = 1'b1;
				reg_dst  = REG_A;
				reg_we   = y != 3'd7;  // CP
				src_sel  = is_alu_mem || is_alu_imm;
			end
			if (is_inc || is_dec) begin
				alu_op   = is_inc ? ALU_INC : ALU_DEC;
				alu_we   = 1'b1;
				flags_we = 1'b1;
				reg_src  = reg_sel_t'(y);
				reg_we   = 1'b1;
			end
			if (is_jp) begin
				pc_load_hi = 1'b1;
				src_sel    = 1'b1;
			end
		end else if (issue) begin
			start   = 1'b1;
			adr_sel = is_ld_load || is_ld_store || is_alu_mem;
			wr      = is_ld_store;
			pc_inc  = is_jp || is_ld_imm || is_alu_imm;  // operand bytes
			if (is_jp && m == 2'd1) begin
				pc_load_lo = 1'b1;
				src_sel    = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			m      <= 2'd0;
			halted <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				m    <= last ? 2'd0 : m + 2'd1;
			end else if (done) begin
				busy <= 1'b0;
			end
			if (halt_now)
				halted <= 1'b1;
		end
	end

endmodule

// ==== hw/sm83_bus.sv ====
`timescale 1ns/1ps

module sm83_bus (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic               wr,
	input  sm83_pkg::adr_t     adr,
	input  sm83_pkg::word_t    wdata,
	input  logic               ir_we,
	input  logic               ack,
	input  sm83_pkg::word_t    din,
	output logic               req,
	output sm83_pkg::bus_req_t bus,
	output logic               done,
	output sm83_pkg::word_t    opcode,
	output sm83_pkg::word_t    dl
);
	import sm83_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,  // req high, waiting for ack
		S_REL   // req dropped, waiting for ack low
	} state_t;

	state_t state;
	logic   fetch;

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= S_IDLE;
			req    <= 1'b0;
			done   <= 1'b0;
			fetch  <= 1'b0;
			opcode <= OP_NOP;  // first decode runs as a plain fetch
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: if (start) begin
					fetch <= ir_we;
					req   <= 1'b1;
					state <= S_REQ;
				end
				S_REQ: if (ack) begin
					if (fetch)
						opcode <= din;
					req   <= 1'b0;
					state <= S_REL;
				end
				default: if (!ack) begin
					done  <= 1'b1;
					state <= S_IDLE;
				end
			endcase
		end
	end

	// request and read data
	always_ff @(posedge clk) begin
		if (state == S_IDLE && start)
			bus <= '{adr: adr, dout: wdata, wr: wr};
		if (state == S_REQ && ack && !bus.wr)
			dl <= din;
	end

endmodule

// ==== hw/sm83_pkg.sv ====
package sm83_pkg;

	localparam int WORD_SIZE = 8;
	localparam int ADR_WIDTH = WORD_SIZE * 2;

	// opcode fields, x = [7:6], y = [5:3], z = [2:0]
	localparam int OP_X_LSB = 6;
	localparam int OP_Y_LSB = 3;
	localparam int OP_Z_LSB = 0;

	typedef logic [WORD_SIZE-1:0] word_t;

	localparam word_t OP_NOP  = 8'h00;
	localparam word_t OP_HALT = 8'h76;  // the LD (HL),(HL) slot
	localparam word_t OP_JP   = 8'hc3;

	typedef struct packed {
		word_t hi;
		word_t lo;
	} adr_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	// first eight follow opcode bits 5:3
	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
		ALU_AND, ALU_XOR, ALU_OR, ALU_CP,
		ALU_INC, ALU_DEC, ALU_PASS
	} alu_op_t;

	typedef enum logic [2:0] {
		REG_B, REG_C, REG_D, REG_E,
		REG_H, REG_L, REG_MEM, REG_A
	} reg_sel_t;

	typedef struct packed {
		adr_t  adr;
		word_t dout;
		logic  wr;
	} bus_req_t;

	typedef struct packed {
		adr_t        pc;
		logic [15:0] af;  // flags in f[7:4]
		logic [15:0] bc;
		logic [15:0] de;
		logic [15:0] hl;
	} cpu_state_t;

endpackage
